// File: hw/bexkat_config.svh
`ifndef BEXKAT_CONFIG_SVH
`define BEXKAT_CONFIG_SVH

// core sizing

`define BX_XLEN 32               // data and address width

`define BX_NREGS 16              // general purpose registers

`define BX_RESET_PC 32'h00000000 // first fetch address

`endif

// File: hw/bexkat_pkg.sv
`include "bexkat_config.svh"

package bexkat_pkg;

  typedef logic [`BX_XLEN-1:0] word_t;
  typedef logic [$clog2(`BX_NREGS)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_CMP    = 4'h3,
    T_MOV    = 4'h4,
    T_ALU    = 4'h9,
    T_LDI    = 4'hc,
    T_BRANCH = 4'hd,
    T_JUMP   = 4'he
  } insn_type_t;

  localparam logic [3:0] OP_HALT = 4'h4;  // T_INH op, the rest are nop

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_SLTU
  } alu_func_t;

  typedef struct packed {
    logic ltu;
    logic lt;
    logic eq;
  } ccr_t;

  typedef struct packed {
    insn_type_t  itype;
    logic [3:0]  op;
    reg_idx_t    ra;
    reg_idx_t    rb;
    reg_idx_t    rc;
    logic [11:0] spare;
  } reg_form_t;

  typedef struct packed {
    insn_type_t  itype;
    logic [3:0]  op;
    reg_idx_t    ra;
    reg_idx_t    rb;
    logic [14:0] imm;
    logic        size;  // extension word follows
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } insn_u;

  typedef struct packed {
    insn_type_t itype;
    logic [3:0] op;
    reg_idx_t   ra;
    word_t      simm;
    word_t      uimm;
    logic       size;
    word_t      ext;
    word_t      pc;
    word_t      rd1;
    word_t      rd2;
    logic       wr_ra;
  } dec_rec_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t ra;
    logic     wr_ra;
    word_t    result;
    logic     taken;
    word_t    target;
    logic     halt;
    ccr_t     ccr;
  } exe_rec_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t ra;
    logic     wr_ra;
    word_t    value;
    ccr_t     ccr;
    logic     taken;
    logic     halt;
  } retire_t;

endpackage

// File: hw/fetch_wb.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module fetch_wb
  import bexkat_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  output word_t wb_adr_o,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i,
  output logic  insn_valid_o,
  output insn_u insn_o,
  output word_t ext_o,
  output word_t pc_o,
  input  logic  retire_i,
  input  logic  redirect_i,
  input  word_t target_i,
  input  logic  halt_i
);

  typedef enum logic [2:0] {S_IDLE, S_INSN, S_EXT, S_WAIT, S_HALT} state_t;

  state_t state_q;
  logic   cyc_q;
  word_t  adr_q;
  word_t  pc_q;
  insn_u  insn_q;
  insn_u  word_in;
  word_t  next_pc;
  logic   ack;

  assign word_in = wb_dat_i;
  assign ack     = wb_ack_i && cyc_q;
  assign next_pc = redirect_i ? target_i :
                   pc_q + (insn_q.imm_form.size ? `BX_XLEN'd8 : `BX_XLEN'd4);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= S_IDLE;
      cyc_q   <= 1'b0;
      adr_q   <= `BX_RESET_PC;
      pc_q    <= `BX_RESET_PC;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          cyc_q   <= 1'b1;
          state_q <= S_INSN;
        end
        S_INSN:
          if (ack)
          begin
            if (word_in.imm_form.size)
            begin
              adr_q   <= pc_q + `BX_XLEN'd4;  // second cycle, back to back
              state_q <= S_EXT;
            end
            else
            begin
              cyc_q   <= 1'b0;
              state_q <= S_WAIT;
            end
          end
        S_EXT:
          if (ack)
          begin
            cyc_q   <= 1'b0;
            state_q <= S_WAIT;
          end
        S_WAIT:
          if (retire_i)
          begin
            if (halt_i)
              state_q <= S_HALT;
            else
            begin
              pc_q    <= next_pc;
              adr_q   <= next_pc;
              cyc_q   <= 1'b1;
              state_q <= S_INSN;
            end
          end
        S_HALT:
          state_q <= S_HALT;  // parked until reset
        default:
          state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == S_INSN && ack)
      insn_q <= word_in;
  end

  assign wb_adr_o     = adr_q;
  assign wb_cyc_o     = cyc_q;
  assign wb_stb_o     = cyc_q;
  assign insn_valid_o = ack && ((state_q == S_INSN && !word_in.imm_form.size) ||
                                state_q == S_EXT);
  assign insn_o       = (state_q == S_EXT) ? insn_q : word_in;
  assign ext_o        = wb_dat_i;  // only meaningful on the second word
  assign pc_o         = pc_q;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module reg_file
  import bexkat_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_idx_t rd_addr1_i,
  input  reg_idx_t rd_addr2_i,
  output word_t    rd_data1_o,
  output word_t    rd_data2_o,
  input  logic     wr_en_i,
  input  reg_idx_t wr_addr_i,
  input  word_t    wr_data_i
);

  word_t regs_q [`BX_NREGS];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `BX_NREGS; i++)
        regs_q[i] <= '0;
    end
    else if (wr_en_i)
      regs_q[wr_addr_i] <= wr_data_i;
  end

  // reads see the old value during a write
  assign rd_data1_o = regs_q[rd_addr1_i];
  assign rd_data2_o = regs_q[rd_addr2_i];

endmodule

// File: hw/decode.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module decode
  import bexkat_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     insn_valid_i,
  input  insn_u    insn_i,
  input  word_t    ext_i,
  input  word_t    pc_i,
  input  logic     wr_en_i,
  input  reg_idx_t wr_addr_i,
  input  word_t    wr_data_i,
  output logic     dec_valid_o,
  output dec_rec_t dec_o
);

  reg_idx_t   rd_addr1;
  reg_idx_t   rd_addr2;
  word_t      rd_data1;
  word_t      rd_data2;
  insn_type_t itype;
  logic       alu_reg_form;
  logic       dec_valid_q;
  dec_rec_t   dec_next;
  dec_rec_t   dec_q;

  assign itype        = insn_i.imm_form.itype;
  assign alu_reg_form = (itype == T_ALU) && !insn_i.reg_form.op[3];

  // alu forms read rb (and rc), the others read ra and rb
  assign rd_addr1 = (itype == T_ALU) ? insn_i.reg_form.rb : insn_i.imm_form.ra;
  assign rd_addr2 = alu_reg_form ? insn_i.reg_form.rc : insn_i.imm_form.rb;

  reg_file u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2),
    .wr_en_i    (wr_en_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i)
  );

  always_comb
  begin
    dec_next.itype = itype;
    dec_next.op    = insn_i.imm_form.op;
    dec_next.ra    = insn_i.imm_form.ra;
    dec_next.simm  = {{(`BX_XLEN-15){insn_i.imm_form.imm[14]}}, insn_i.imm_form.imm};
    dec_next.uimm  = {{(`BX_XLEN-15){1'b0}}, insn_i.imm_form.imm};
    dec_next.size  = insn_i.imm_form.size;
    dec_next.ext   = ext_i;
    dec_next.pc    = pc_i;
    dec_next.rd1   = rd_data1;
    dec_next.rd2   = rd_data2;
    dec_next.wr_ra = (itype == T_MOV) || (itype == T_LDI) || (itype == T_ALU);
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      dec_valid_q <= 1'b0;
    else
      dec_valid_q <= insn_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (insn_valid_i)
      dec_q <= dec_next;
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module alu
  import bexkat_pkg::*;
(
  input  word_t     in1_i,
  input  word_t     in2_i,
  input  alu_func_t func_i,
  output word_t     out_o,
  output logic      c_o,
  output logic      z_o,
  output logic      n_o,
  output logic      v_o
);

  localparam int MSB = `BX_XLEN - 1;

  logic [`BX_XLEN:0] diff;

  assign diff = {1'b0, in1_i} - {1'b0, in2_i};

  // flags always come from in1 - in2
  assign c_o = diff[`BX_XLEN];  // borrow, unsigned less than
  assign z_o = (diff[MSB:0] == '0);
  assign n_o = diff[MSB];
  assign v_o = (in1_i[MSB] ^ in2_i[MSB]) & (in1_i[MSB] ^ diff[MSB]);

  always_comb
  begin
    case (func_i)
      ALU_ADD:  out_o = in1_i + in2_i;
      ALU_SUB:  out_o = diff[MSB:0];
      ALU_AND:  out_o = in1_i & in2_i;
      ALU_OR:   out_o = in1_i | in2_i;
      ALU_XOR:  out_o = in1_i ^ in2_i;
      ALU_SHL:  out_o = in1_i << in2_i[$clog2(`BX_XLEN)-1:0];
      ALU_SHR:  out_o = in1_i >> in2_i[$clog2(`BX_XLEN)-1:0];  // logical
      ALU_SLTU: out_o = {{(`BX_XLEN-1){1'b0}}, c_o};
      default:  out_o = in1_i + in2_i;
    endcase
  end

endmodule

// File: hw/execute.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module execute
  import bexkat_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     dec_valid_i,
  input  dec_rec_t dec_i,
  output logic     exe_valid_o,
  output exe_rec_t exe_o
);

  word_t     alu_in1;
  word_t     alu_in2;
  word_t     alu_out;
  alu_func_t alu_func;
  logic      alu_c;
  logic      alu_z;
  logic      alu_n;
  logic      alu_v;
  word_t     simm_x4;
  word_t     result;
  logic      taken;
  ccr_t      ccr_q;
  ccr_t      ccr_next;
  logic      exe_valid_q;
  exe_rec_t  exe_q;

  assign simm_x4 = {dec_i.simm[`BX_XLEN-3:0], 2'b00};  // word offset

  always_comb
  begin
    alu_in1  = dec_i.rd1;
    alu_in2  = dec_i.rd2;
    alu_func = alu_func_t'(dec_i.op[2:0]);
    case (dec_i.itype)
      T_CMP:
        alu_func = ALU_SUB;
      T_BRANCH:
      begin
        alu_in1  = dec_i.pc;
        alu_in2  = simm_x4;
        alu_func = ALU_ADD;
      end
      T_JUMP:
      begin
        alu_in2  = simm_x4;
        alu_func = ALU_ADD;
      end
      T_ALU:
        if (dec_i.op[3])
          alu_in2 = dec_i.simm;
      default: ;
    endcase
  end

  alu u_alu (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .z_o    (alu_z),
    .n_o    (alu_n),
    .v_o    (alu_v)
  );

  assign ccr_next = (dec_i.itype == T_CMP) ? ccr_t'{ltu: alu_c, lt: alu_n ^ alu_v, eq: alu_z}
                                           : ccr_q;

  always_comb
  begin
    case (dec_i.itype)
      T_LDI:   result = dec_i.size ? dec_i.ext : dec_i.uimm;
      T_MOV:   result = dec_i.rd2;
      default: result = alu_out;
    endcase
  end

  // conditions test the flags left by the last compare
  always_comb
  begin
    taken = 1'b0;
    case (dec_i.itype)
      T_BRANCH:
        case (dec_i.op)
          4'h0:    taken = 1'b1;                      // bra
          4'h1:    taken = ccr_q.eq;                  // beq
          4'h2:    taken = !ccr_q.eq;                 // bne
          4'h3:    taken = !(ccr_q.ltu | ccr_q.eq);   // bgtu
          4'h4:    taken = !(ccr_q.lt | ccr_q.eq);    // bgt
          4'h5:    taken = !ccr_q.lt;                 // bge
          4'h6:    taken = ccr_q.lt | ccr_q.eq;       // ble
          4'h7:    taken = ccr_q.lt;                  // blt
          4'h8:    taken = !ccr_q.ltu;                // bgeu
          4'h9:    taken = ccr_q.ltu;                 // bltu
          4'ha:    taken = ccr_q.ltu | ccr_q.eq;      // bleu
          default: taken = 1'b0;                      // brn
        endcase
      T_JUMP:
        taken = 1'b1;
      default:
        taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ccr_q       <= '0;
      exe_valid_q <= 1'b0;
    end
    else
    begin
      exe_valid_q <= dec_valid_i;
      if (dec_valid_i)
        ccr_q <= ccr_next;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dec_valid_i)
    begin
      exe_q.pc     <= dec_i.pc;
      exe_q.ra     <= dec_i.ra;
      exe_q.wr_ra  <= dec_i.wr_ra;
      exe_q.result <= result;
      exe_q.taken  <= taken;
      exe_q.target <= (dec_i.itype == T_JUMP && dec_i.size) ? dec_i.ext : alu_out;
      exe_q.halt   <= (dec_i.itype == T_INH) && (dec_i.op == OP_HALT);
      exe_q.ccr    <= ccr_next;
    end
  end

  assign exe_valid_o = exe_valid_q;
  assign exe_o       = exe_q;

endmodule

// File: hw/result.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module result
  import bexkat_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     exe_valid_i,
  input  exe_rec_t exe_i,
  output logic     wr_en_o,
  output reg_idx_t wr_addr_o,
  output word_t    wr_data_o,
  output logic     redirect_o,
  output word_t    target_o,
  output logic     retire_valid_o,
  output retire_t  retire_o,
  output logic     halt_o
);

  logic    retire_valid_q;
  logic    halt_q;
  retire_t retire_q;
  word_t   target_q;

  // register file updates on the same edge the retire record is taken
  assign wr_en_o   = exe_valid_i && exe_i.wr_ra;
  assign wr_addr_o = exe_i.ra;
  assign wr_data_o = exe_i.result;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      retire_valid_q <= 1'b0;
      halt_q         <= 1'b0;
    end
    else
    begin
      retire_valid_q <= exe_valid_i;
      if (exe_valid_i && exe_i.halt)
        halt_q <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (exe_valid_i)
    begin
      retire_q <= '{pc: exe_i.pc, ra: exe_i.ra, wr_ra: exe_i.wr_ra, value: exe_i.result,
                    ccr: exe_i.ccr, taken: exe_i.taken, halt: exe_i.halt};
      target_q <= exe_i.target;
    end
  end

  assign redirect_o     = retire_q.taken;
  assign target_o       = target_q;
  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;
  assign halt_o         = halt_q;

endmodule

// File: hw/bexkat_core.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module bexkat_core
  import bexkat_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  output word_t   wb_adr_o,
  output logic    wb_cyc_o,
  output logic    wb_stb_o,
  output logic    wb_we_o,
  input  word_t   wb_dat_i,
  input  logic    wb_ack_i,
  output logic    retire_valid_o,
  output retire_t retire_o,
  output logic    halt_o
);

  logic     insn_valid;
  insn_u    insn;
  word_t    ext;
  word_t    fetch_pc;
  logic     dec_valid;
  dec_rec_t dec;
  logic     exe_valid;
  exe_rec_t exe;
  logic     wr_en;
  reg_idx_t wr_addr;
  word_t    wr_data;
  logic     redirect;
  word_t    target;
  logic     retire_valid;
  logic     halt;

  assign wb_we_o = 1'b0;  // fetch only, no data bus

  fetch_wb u_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wb_adr_o     (wb_adr_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .insn_valid_o (insn_valid),
    .insn_o       (insn),
    .ext_o        (ext),
    .pc_o         (fetch_pc),
    .retire_i     (retire_valid),
    .redirect_i   (redirect),
    .target_i     (target),
    .halt_i       (halt)
  );

  decode u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .insn_valid_i (insn_valid),
    .insn_i       (insn),
    .ext_i        (ext),
    .pc_i         (fetch_pc),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec)
  );

  execute u_execute (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .exe_valid_o (exe_valid),
    .exe_o       (exe)
  );

  result u_result (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .exe_valid_i    (exe_valid),
    .exe_i          (exe),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .redirect_o     (redirect),
    .target_o       (target),
    .retire_valid_o (retire_valid),
    .retire_o       (retire_o),
    .halt_o         (halt)
  );

  assign retire_valid_o = retire_valid;
  assign halt_o         = halt;

endmodule

// File: tb/bexkat_core_properties.sv
`timescale 1ns/100ps

module bexkat_core_properties
  import bexkat_pkg::*;
(
  input logic  clk_i,
  input logic  rst_i,
  input logic  wb_cyc_i,
  input logic  wb_stb_i,
  input word_t wb_adr_i,
  input logic  wb_ack_i,
  input logic  retire_valid_i,
  input logic  halt_i
);

  // a request ends with its ack unless the extension word follows
  ack_ends_req: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_cyc_i && wb_stb_i && wb_ack_i |=>
      !wb_stb_i || wb_adr_i == $past(wb_adr_i) + 32'd4)
    else $error("fetch request still open after ack");

  // classic cycle holds until ack
  adr_held: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
    else $error("fetch request changed before ack");

  retire_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_i |=> !retire_valid_i)
    else $error("retire valid held longer than one cycle");

  halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_i |-> !wb_stb_i)
    else $error("fetch request issued while halted");

endmodule

// File: tb/tb_bexkat_core.sv
`timescale 1ns/100ps
`include "bexkat_config.svh"

module tb_bexkat_core
  import bexkat_pkg::*;
();

  localparam int MEM_WORDS      = 256;
  localparam int NUM_TESTS      = 16;
  localparam int MIN_INSNS      = 12;
  localparam int MAX_SLOTS      = 32;
  localparam int RETIRE_TIMEOUT = 60;
  localparam int HALT_WATCH     = 12;

  localparam int K_ALUR = 0;
  localparam int K_ALUI = 1;
  localparam int K_CMP  = 2;
  localparam int K_LDI  = 3;
  localparam int K_LDIX = 4;
  localparam int K_MOV  = 5;
  localparam int K_BR   = 6;
  localparam int K_JREG = 7;
  localparam int K_JEXT = 8;
  localparam int K_JSET = 9;  // ldi that feeds the register jump after it
  localparam int K_HALT = 10;

  logic    clk;
  logic    rst;
  word_t   wb_adr;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  word_t   wb_dat;
  logic    wb_ack;
  logic    retire_valid;
  retire_t retire_rec;
  logic    halt;

  word_t mem [MEM_WORDS];
  int    kind [MAX_SLOTS+1];
  int    start [MAX_SLOTS+2];  // word address of each slot
  bit    landable [MAX_SLOTS+1];
  int    ack_wait;

  word_t m_regs [`BX_NREGS];
  ccr_t  m_ccr;
  word_t m_pc;

  int errors;
  int test_errors;
  int total_retired;
  bit timed_out;

  bexkat_core uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .wb_adr_o       (wb_adr),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_we_o        (wb_we),
    .wb_dat_i       (wb_dat),
    .wb_ack_i       (wb_ack),
    .retire_valid_o (retire_valid),
    .retire_o       (retire_rec),
    .halt_o         (halt)
  );

  bind bexkat_core bexkat_core_properties u_props (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_o),
    .wb_stb_i       (wb_stb_o),
    .wb_adr_i       (wb_adr_o),
    .wb_ack_i       (wb_ack_i),
    .retire_valid_i (retire_valid_o),
    .halt_i         (halt_o)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #20 clk = ~clk;
  end

  // wishbone slave, 0 to 3 wait cycles per word
  initial
  begin
    wb_ack   = 1'b0;
    wb_dat   = '0;
    ack_wait = 0;
    forever
    begin
      @(posedge clk);
      #1;
      if (rst || !wb_cyc || !wb_stb || wb_ack)
      begin
        wb_ack   = 1'b0;
        ack_wait = rand_below(4);
      end
      else if (ack_wait == 0)
      begin
        check_we(wb_we, 1'b0);
        wb_ack = 1'b1;
        wb_dat = mem[wb_adr[9:2]];
      end
      else
        ack_wait = ack_wait - 1;
    end
  end

  function automatic int rand_below(int n);
    return int'($urandom % n);
  endfunction

  function automatic int pick_reg();
    return rand_below(`BX_NREGS);
  endfunction

  function automatic word_t enc_imm(insn_type_t t, int op, int ra, int rb, int imm, bit size);
    return {t, 4'(op), 4'(ra), 4'(rb), 15'(imm), size};
  endfunction

  function automatic word_t enc_reg(insn_type_t t, int op, int ra, int rb, int rc);
    return {t, 4'(op), 4'(ra), 4'(rb), 4'(rc), 12'h000};
  endfunction

  // forward only, never onto the jump half of a pair
  function automatic int pick_target(int from, int n);
    int j;
    j = from + 1 + rand_below(4);
    if (j > n)
      j = n;
    while (!landable[j])
      j++;
    return j;
  endfunction

  task automatic gen_program();
    int n;
    int i;
    int j;
    int w;
    int off;
    int rx;
    int ra;
    n = MIN_INSNS + rand_below(MAX_SLOTS - MIN_INSNS + 1);
    for (int k = 0; k < MEM_WORDS; k++)
      mem[k] = {T_INH, OP_HALT, 14'h0, 8'(k), 2'b00};
    i = 0;
    while (i < n)
    begin
      kind[i]     = rand_below(9);
      landable[i] = 1'b1;
      if (kind[i] == K_JREG && i + 1 < n)
      begin
        kind[i]       = K_JSET;
        kind[i+1]     = K_JREG;
        landable[i+1] = 1'b0;
        i += 2;
      end
      else
      begin
        if (kind[i] == K_JREG)
          kind[i] = K_CMP;
        i++;
      end
    end
    kind[n]     = K_HALT;
    landable[n] = 1'b1;
    start[0]    = 0;
    for (int k = 0; k <= n; k++)
      start[k+1] = start[k] + ((kind[k] == K_LDIX || kind[k] == K_JEXT) ? 2 : 1);
    for (i = 0; i <= n; i++)
    begin
      w = start[i];
      case (kind[i])
        K_ALUR: mem[w] = enc_reg(T_ALU, rand_below(8), pick_reg(), pick_reg(), pick_reg());
        K_ALUI: mem[w] = enc_imm(T_ALU, 8 + rand_below(8), pick_reg(), pick_reg(),
                                 rand_below(32768), 1'b0);
        K_CMP:
        begin
          ra     = pick_reg();
          mem[w] = enc_imm(T_CMP, 0, ra, (rand_below(4) == 0) ? ra : pick_reg(), 0, 1'b0);
        end
        K_LDI:  mem[w] = enc_imm(T_LDI, 0, pick_reg(), 0, rand_below(32768), 1'b0);
        K_LDIX:
        begin
          mem[w]   = enc_imm(T_LDI, 0, pick_reg(), 0, 0, 1'b1);
          mem[w+1] = $urandom;
        end
        K_MOV:  mem[w] = enc_imm(T_MOV, 0, pick_reg(), pick_reg(), 0, 1'b0);
        K_BR:
        begin
          j      = pick_target(i, n);
          mem[w] = enc_imm(T_BRANCH, rand_below(16), 0, 0, start[j] - start[i], 1'b0);
        end
        K_JSET:
        begin
          j   = pick_target(i + 1, n);
          off = rand_below(4);
          if (off > start[j])
            off = start[j];
          rx       = pick_reg();
          mem[w]   = enc_imm(T_LDI, 0, rx, 0, (start[j] - off) * 4, 1'b0);
          mem[w+1] = enc_imm(T_JUMP, 0, rx, 0, off, 1'b0);
        end
        K_JEXT:
        begin
          j        = pick_target(i, n);
          mem[w]   = enc_imm(T_JUMP, 0, pick_reg(), 0, rand_below(32768), 1'b1);
          mem[w+1] = start[j] * 4;
        end
        K_HALT: mem[w] = {T_INH, OP_HALT, 24'h000000};
        default: ;  // jump word already written by its ldi
      endcase
    end
  endtask

  function automatic void model_reset();
    for (int k = 0; k < `BX_NREGS; k++)
      m_regs[k] = '0;
    m_ccr = '0;
    m_pc  = `BX_RESET_PC;
  endfunction

  function automatic word_t alu_ref(logic [2:0] f, word_t a, word_t b);
    case (alu_func_t'(f))
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SHL: return a << b[4:0];
      ALU_SHR: return a >> b[4:0];
      default: return {31'h0, a < b};  // sltu
    endcase
  endfunction

  function automatic logic branch_taken(logic [3:0] op, ccr_t c);
    case (op)
      4'h0:    return 1'b1;
      4'h1:    return c.eq;
      4'h2:    return !c.eq;
      4'h3:    return !c.ltu && !c.eq;  // unsigned greater
      4'h4:    return !c.lt && !c.eq;
      4'h5:    return !c.lt;
      4'h6:    return c.lt || c.eq;
      4'h7:    return c.lt;
      4'h8:    return !c.ltu;
      4'h9:    return c.ltu;
      4'ha:    return c.ltu || c.eq;
      default: return 1'b0;
    endcase
  endfunction

  function automatic retire_t model_step();
    retire_t    r;
    word_t      w;
    word_t      ext;
    word_t      simm;
    word_t      val;
    word_t      target;
    logic [3:0] op;
    logic [3:0] ra;
    logic       size;
    logic       taken;
    w      = mem[m_pc[9:2]];
    ext    = mem[m_pc[9:2] + 8'd1];
    size   = w[0];
    op     = w[27:24];
    ra     = w[23:20];
    simm   = {{17{w[15]}}, w[15:1]};
    val    = '0;
    target = '0;
    taken  = 1'b0;
    r      = '0;
    r.pc   = m_pc;
    r.ra   = ra;
    case (w[31:28])
      T_ALU:
      begin
        val     = alu_ref(op[2:0], m_regs[w[19:16]], op[3] ? simm : m_regs[w[15:12]]);
        r.wr_ra = 1'b1;
      end
      T_CMP:
      begin
        m_ccr.ltu = m_regs[ra] < m_regs[w[19:16]];
        m_ccr.lt  = $signed(m_regs[ra]) < $signed(m_regs[w[19:16]]);
        m_ccr.eq  = m_regs[ra] == m_regs[w[19:16]];
      end
      T_LDI:
      begin
        val     = size ? ext : {17'h0, w[15:1]};
        r.wr_ra = 1'b1;
      end
      T_MOV:
      begin
        val     = m_regs[w[19:16]];
        r.wr_ra = 1'b1;
      end
      T_BRANCH:
      begin
        taken  = branch_taken(op, m_ccr);
        target = m_pc + (simm << 2);
      end
      T_JUMP:
      begin
        taken  = 1'b1;
        target = size ? ext : m_regs[ra] + (simm << 2);
      end
      T_INH:
        r.halt = (op == OP_HALT);
      default: ;
    endcase
    if (r.wr_ra)
      m_regs[ra] = val;
    r.value = val;
    r.ccr   = m_ccr;
    r.taken = taken;
    m_pc    = taken ? target : m_pc + (size ? 32'd8 : 32'd4);
    return r;
  endfunction

  task automatic show_mismatch(string name, word_t got, word_t want);
    $display("error at %0t: %s got %h expected %h", $time, name, got, want);
    errors++;
    test_errors++;
  endtask

  task automatic check_retire(retire_t got, retire_t want);
    if (got.pc !== want.pc)
      show_mismatch("retire_o.pc", got.pc, want.pc);
    if (got.ra !== want.ra)
      show_mismatch("retire_o.ra", word_t'(got.ra), word_t'(want.ra));
    if (got.wr_ra !== want.wr_ra)
      show_mismatch("retire_o.wr_ra", word_t'(got.wr_ra), word_t'(want.wr_ra));
    if (want.wr_ra && got.value !== want.value)  // value only defined on a write
      show_mismatch("retire_o.value", got.value, want.value);
    if (got.ccr !== want.ccr)
      show_mismatch("retire_o.ccr", word_t'(got.ccr), word_t'(want.ccr));
    if (got.taken !== want.taken)
      show_mismatch("retire_o.taken", word_t'(got.taken), word_t'(want.taken));
    if (got.halt !== want.halt)
      show_mismatch("retire_o.halt", word_t'(got.halt), word_t'(want.halt));
  endtask

  task automatic check_halt(logic got, logic want);
    if (got !== want)
      show_mismatch("halt_o", word_t'(got), word_t'(want));
  endtask

  task automatic check_we(logic got, logic want);
    if (got !== want)
      show_mismatch("wb_we_o", word_t'(got), word_t'(want));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (8)
      @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic wait_retire(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < RETIRE_TIMEOUT)
    begin
      @(negedge clk);
      ok = retire_valid;
      cycles++;
    end
    if (!ok)
      $display("timeout: nothing retired for %0d cycles after pc %h", RETIRE_TIMEOUT, m_pc);
  endtask

  task automatic watch_after_halt();
    repeat (HALT_WATCH)
    begin
      @(negedge clk);
      check_halt(halt, 1'b1);
      if (wb_stb || retire_valid)
      begin
        $display("the core kept fetching or retiring after halt at %0t", $time);
        errors++;
        test_errors++;
      end
    end
  endtask

  task automatic run_test(int t);
    retire_t want;
    bit      ok;
    bit      halted;
    int      retired;
    test_errors = 0;
    retired     = 0;
    halted      = 1'b0;
    gen_program();
    model_reset();
    apply_reset();
    while (!halted && !timed_out && retired <= MAX_SLOTS)
    begin
      wait_retire(ok);
      if (!ok)
        timed_out = 1'b1;
      else
      begin
        want = model_step();
        check_retire(retire_rec, want);
        check_halt(halt, want.halt);
        halted = want.halt;
        retired++;
      end
    end
    if (halted)
      watch_after_halt();
    else if (!timed_out)
    begin
      $display("test %0d retired %0d instructions without reaching halt", t, retired);
      errors++;
      test_errors++;
    end
    total_retired += retired;
    $display("test %0d: %0d instructions retired, %0d errors", t, retired, test_errors);
  endtask

  initial
  begin
    rst           = 1'b1;
    errors        = 0;
    test_errors   = 0;
    total_retired = 0;
    timed_out     = 1'b0;
    void'($urandom(92));
    for (int t = 0; t < NUM_TESTS && !timed_out; t++)
      run_test(t);
    $display("%0d tests, %0d instructions retired, %0d errors",
             NUM_TESTS, total_retired, errors);
    if (errors == 0 && !timed_out)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: bexkat_core.f
+incdir+hw
hw/bexkat_pkg.sv
hw/fetch_wb.sv
hw/reg_file.sv
hw/decode.sv
hw/alu.sv
hw/execute.sv
hw/result.sv
hw/bexkat_core.sv
tb/bexkat_core_properties.sv
tb/tb_bexkat_core.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the core and testbench with Verilator, run, check the log"
	@echo "  clean  remove the Verilator build and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_bexkat_core \
		-Mdir obj_dir -f bexkat_core.f
	./obj_dir/Vtb_bexkat_core | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
